//--- Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module tb_vector_decoder -f vector_decoder.f

run: compile
	@out="$$(./obj_dir/Vtb_vector_decoder)"; echo "$$out"; \
		echo "$$out" | grep -qx "PASS: all tests"

clean:
	rm -rf obj_dir

//--- apu_capture.sv
// holds the accepted instruction and scalars until the next accept; values read zero after reset
`timescale 1ns/1ps
`default_nettype none

module apu_capture (
    input wire clk,
    input wire n_reset,
    input wire accept_i,
    input wire vdec_pkg::apu_operands_t operands_i,
    output vdec_pkg::instr_fields_t fields_o,
    output logic [vdec_pkg::xlen-1:0] scalar_operand1_o,
    output logic [vdec_pkg::xlen-1:0] scalar_operand2_o
);
    import vdec_pkg::*;

    apu_operands_t held;
    logic [xlen-1:0] instr;

    always_ff @(posedge clk, negedge n_reset)
    begin
        if (!n_reset)
        begin
            held <= '0;
        end
        else if (accept_i)
        begin
            held <= operands_i;
        end
    end

    assign instr = held.instr;
    assign scalar_operand1_o = held.scalar1;
    assign scalar_operand2_o = held.scalar2;

    // standard OP-V field positions
    always_comb
    begin
        fields_o.major = v_major_t'(instr[6:0]);
        fields_o.funct3 = v_funct3_t'(instr[14:12]);
        fields_o.funct6 = v_funct6_t'(instr[31:26]);
        fields_o.source1 = instr[19:15];
        fields_o.source2 = instr[24:20];
        fields_o.destination = instr[11:7];
        // vsetvli zimm lives in 30:20
        fields_o.imm_raw = instr[30:20];
    end

endmodule

`default_nettype wire

//--- element_sequencer.sv
// steps four elements per cycle; vl_i and vsew_i must stay stable while an instruction executes
`timescale 1ns/1ps
`default_nettype none

module element_sequencer (
    input wire clk,
    input wire n_reset,
    input wire apu_req_i,
    input wire [vdec_pkg::vl_w-1:0] vl_i,
    input wire [1:0] vsew_i,
    input wire vdec_pkg::instr_fields_t fields_i,
    input wire vdec_pkg::seq_ctrl_t seq_ctrl_i,
    output logic accept_o,
    output logic apu_gnt_o,
    output logic apu_rvalid_o,
    output logic core_halt_o,
    output logic [vdec_pkg::vreg_addr_w-1:0] vs1_addr_o,
    output logic [vdec_pkg::vreg_addr_w-1:0] vs2_addr_o,
    output logic [vdec_pkg::vreg_addr_w-1:0] vd_addr_o,
    output logic [1:0] elements_to_write_o
);
    import vdec_pkg::*;

    typedef enum logic {S_WAIT, S_EXEC} seq_state_t;

    seq_state_t state;
    seq_state_t next_state;
    logic [elems_per_cycle_w-1:0] count;
    logic [elems_per_cycle_w-1:0] max_count;
    logic [vl_w-1:0] vl_zero_indexed;
    logic [vreg_addr_w-1:0] step;
    logic last;

    // (vl - 1) / 4 extra cycles for vector work
    assign vl_zero_indexed = vl_i - 1'b1;
    assign max_count = seq_ctrl_i.multi_cycle ? vl_zero_indexed[2 +: elems_per_cycle_w] : '0;
    assign last = (count == max_count);

    assign apu_gnt_o = (state == S_WAIT);
    assign accept_o = apu_gnt_o && apu_req_i;
    assign core_halt_o = (state == S_EXEC);
    assign apu_rvalid_o = core_halt_o && last;

    always_comb
    begin
        next_state = state;
        case (state)
            S_WAIT:
                if (accept_o)
                    next_state = S_EXEC;
            S_EXEC:
                if (last)
                    next_state = S_WAIT;
            default:
                next_state = S_WAIT;
        endcase
    end

    always_ff @(posedge clk, negedge n_reset)
    begin
        if (!n_reset)
        begin
            state <= S_WAIT;
            count <= '0;
        end
        else
        begin
            state <= next_state;
            if (state == S_EXEC && !last)
                count <= count + 1'b1;
            else
                count <= '0;
        end
    end

    // 16-bit elements span two registers per group of four
    assign step = (vsew_i == 2'd1) ? vreg_addr_w'({count, 1'b0}) : vreg_addr_w'(count);

    assign vs1_addr_o = fields_i.source1 + step;
    assign vs2_addr_o = fields_i.source2 + step;
    assign vd_addr_o = seq_ctrl_i.fix_vd ? fields_i.destination : fields_i.destination + step;

    always_comb
    begin
        elements_to_write_o = 2'd0;
        if (seq_ctrl_i.multi_cycle && last)
        begin
            // reductions leave a single result element
            elements_to_write_o = seq_ctrl_i.reduction ? 2'd1 : vl_i[1:0];
        end
    end

endmodule

`default_nettype wire

//--- op_decoder.sv
// combinational OP-V decode; all controls idle while not executing, unknown opcodes decode to no-op
`timescale 1ns/1ps
`default_nettype none

module op_decoder (
    input wire exec_i,
    input wire vdec_pkg::instr_fields_t fields_i,
    output vdec_pkg::reg_ctrl_t reg_ctrl_o,
    output vdec_pkg::pe_ctrl_t pe_ctrl_o,
    output vdec_pkg::seq_ctrl_t seq_ctrl_o,
    output logic [vdec_pkg::imm_w-1:0] immediate_operand_o
);
    import vdec_pkg::*;

    logic is_vx;
    logic is_vi;
    logic is_mvv;

    assign is_vx = (fields_i.funct3 == V_OPIVX) || (fields_i.funct3 == V_OPMVX);
    assign is_vi = (fields_i.funct3 == V_OPIVI);
    assign is_mvv = (fields_i.funct3 == V_OPMVV);

    assign immediate_operand_o = (fields_i.funct3 == V_OPCFG) ? fields_i.imm_raw
                                                              : imm_w'(fields_i.source1);

    always_comb
    begin
        // all-zero is write disabled, ADD, VS1, no saturation, ARITH, VL
        reg_ctrl_o = '0;
        pe_ctrl_o = '0;
        seq_ctrl_o = '0;

        if (exec_i && fields_i.major == V_MAJOR_OP_V)
        begin
            if (fields_i.funct3 == V_OPCFG)
            begin
                // vsetvli: rs1 = x0 keeps vl (rd = x0) or requests vlmax
                reg_ctrl_o.csr_write = 1'b1;
                reg_ctrl_o.preserve_vl = (fields_i.source1 == '0) && (fields_i.destination == '0);
                reg_ctrl_o.set_vl_max = (fields_i.source1 == '0) && (fields_i.destination != '0);
            end
            else
            begin
                // most arithmetic writes vd over vl elements
                reg_ctrl_o.vec_reg_write = 1'b1;
                seq_ctrl_o.multi_cycle = 1'b1;

                case (fields_i.funct6)
                    F6_VADD:
                    begin
                        if (is_vx)
                            pe_ctrl_o.operand_select = PE_OPERAND_SCALAR;
                        else if (is_mvv)
                        begin
                            // vredsum
                            pe_ctrl_o.operand_select = PE_OPERAND_RIPPLE;
                            seq_ctrl_o.fix_vd = 1'b1;
                            seq_ctrl_o.reduction = 1'b1;
                        end
                    end
                    F6_VSUB:
                        pe_ctrl_o.pe_op = PE_ARITH_SUB;
                    F6_VMIN, F6_VMAX:
                    begin
                        pe_ctrl_o.pe_op = PE_ARITH_SUB;
                        pe_ctrl_o.output_mode = (fields_i.funct6 == F6_VMIN)
                                                ? PE_OP_MODE_PASS_MIN : PE_OP_MODE_PASS_MAX;
                        if (is_vx)
                            pe_ctrl_o.operand_select = PE_OPERAND_SCALAR;
                        else if (is_mvv && fields_i.funct6 == F6_VMAX)
                        begin
                            // vredmax
                            pe_ctrl_o.operand_select = PE_OPERAND_RIPPLE;
                            seq_ctrl_o.fix_vd = 1'b1;
                            seq_ctrl_o.reduction = 1'b1;
                        end
                    end
                    F6_VAND:
                        pe_ctrl_o.pe_op = PE_ARITH_AND;
                    F6_VOR:
                        pe_ctrl_o.pe_op = PE_ARITH_OR;
                    F6_VXOR:
                        pe_ctrl_o.pe_op = PE_ARITH_XOR;
                    F6_VWXUNARY0:
                    begin
                        // vmv.x.s returns element 0 of vs2 to the core only
                        reg_ctrl_o.vec_reg_write = 1'b0;
                        seq_ctrl_o.multi_cycle = 1'b0;
                        reg_ctrl_o.apu_result_select = APU_RESULT_SRC_VS2_0;
                    end
                    F6_VMV:
                    begin
                        reg_ctrl_o.vd_data_src = VREG_WB_SRC_SCALAR;
                        if (is_vi)
                            pe_ctrl_o.operand_select = PE_OPERAND_IMMEDIATE;
                        else if (is_vx)
                            pe_ctrl_o.operand_select = PE_OPERAND_SCALAR;
                    end
                    F6_VSADD:
                        pe_ctrl_o.saturate_mode = PE_SAT;
                    F6_VSLL:
                    begin
                        // OPMVV here is vmul
                        pe_ctrl_o.pe_op = is_mvv ? PE_ARITH_MUL : PE_ARITH_LSHIFT;
                        if (is_vx)
                            pe_ctrl_o.operand_select = PE_OPERAND_SCALAR;
                        else if (is_vi)
                            pe_ctrl_o.operand_select = PE_OPERAND_IMMEDIATE;
                    end
                    F6_VSMUL:
                    begin
                        pe_ctrl_o.pe_op = PE_ARITH_MUL;
                        pe_ctrl_o.saturate_mode = PE_SAT_UPPER;
                        if (is_vx)
                            pe_ctrl_o.operand_select = PE_OPERAND_SCALAR;
                    end
                    F6_VSRL, F6_VSRA:
                    begin
                        pe_ctrl_o.pe_op = (fields_i.funct6 == F6_VSRL)
                                          ? PE_ARITH_RSHIFT_LOG : PE_ARITH_RSHIFT_AR;
                        if (is_vx)
                            pe_ctrl_o.operand_select = PE_OPERAND_SCALAR;
                        else if (is_vi)
                        begin
                            // shift amount is never sign extended
                            pe_ctrl_o.operand_select = PE_OPERAND_IMMEDIATE;
                            pe_ctrl_o.unsigned_immediate = 1'b1;
                        end
                    end
                    F6_VWREDSUM:
                    begin
                        pe_ctrl_o.operand_select = PE_OPERAND_RIPPLE;
                        pe_ctrl_o.widening = 2'b01;
                        pe_ctrl_o.wide_vs1 = 1'b1;
                        seq_ctrl_o.fix_vd = 1'b1;
                        seq_ctrl_o.reduction = 1'b1;
                    end
                    F6_VWMUL:
                    begin
                        pe_ctrl_o.pe_op = PE_ARITH_MUL;
                        pe_ctrl_o.widening = 2'b01;
                        if (fields_i.funct3 == V_OPMVX)
                            pe_ctrl_o.operand_select = PE_OPERAND_SCALAR;
                    end
                    default:
                    begin
                        // unsupported, single cycle with nothing written
                        reg_ctrl_o.vec_reg_write = 1'b0;
                        seq_ctrl_o.multi_cycle = 1'b0;
                    end
                endcase
            end
        end
    end

endmodule

`default_nettype wire

//--- tb_vector_decoder.sv
// self-checking testbench; needs simulator timing support and stops at the first mismatch
`timescale 1ns/1ps
`default_nettype none

module tb_vector_decoder;
    import vdec_pkg::*;

    // 20 add/sub, 12 reductions, 8 vsetvli, 16 table entries, 2 in the held-request run
    localparam int n_instr = 58;

    logic clk = 1'b0;
    logic n_reset;
    logic apu_req;
    apu_operands_t operands;
    logic [vl_w-1:0] vl;
    logic [1:0] vsew;
    logic apu_gnt;
    logic apu_rvalid;
    logic core_halt;
    logic [xlen-1:0] scalar1;
    logic [xlen-1:0] scalar2;
    logic [imm_w-1:0] immediate;
    logic [vreg_addr_w-1:0] vs1_addr;
    logic [vreg_addr_w-1:0] vs2_addr;
    logic [vreg_addr_w-1:0] vd_addr;
    logic [1:0] elements_to_write;
    reg_ctrl_t reg_ctrl;
    pe_ctrl_t pe_ctrl;
    integer seed;
    logic [31:0] noop_instr;

    vector_decoder i_dut (
        .clk(clk),
        .n_reset(n_reset),
        .apu_req_i(apu_req),
        .apu_operands_i(operands),
        .vl_i(vl),
        .vsew_i(vsew),
        .apu_gnt_o(apu_gnt),
        .apu_rvalid_o(apu_rvalid),
        .core_halt_o(core_halt),
        .scalar_operand1_o(scalar1),
        .scalar_operand2_o(scalar2),
        .immediate_operand_o(immediate),
        .vs1_addr_o(vs1_addr),
        .vs2_addr_o(vs2_addr),
        .vd_addr_o(vd_addr),
        .elements_to_write_o(elements_to_write),
        .reg_ctrl_o(reg_ctrl),
        .pe_ctrl_o(pe_ctrl)
    );

    always #10 clk = ~clk;

    task automatic stop_with_failure();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            $display("ERROR %s got 0x%0h expected 0x%0h", name, got, exp);
            stop_with_failure();
        end
    endtask

    // grant and halt are exact complements out of reset
    assert property (@(posedge clk) disable iff (!n_reset) apu_gnt != core_halt)
    else
    begin
        $display("grant and halt disagree about the decoder state");
        stop_with_failure();
    end

    assert property (@(posedge clk) disable iff (!n_reset) apu_rvalid |-> core_halt)
    else
    begin
        $display("rvalid pulsed outside an execute cycle");
        stop_with_failure();
    end

    // back to waiting right after completion
    assert property (@(posedge clk) disable iff (!n_reset) apu_rvalid |=> apu_gnt)
    else
    begin
        $display("grant did not return in the cycle after rvalid");
        stop_with_failure();
    end

    function automatic logic [31:0] encode_op_v(input logic [5:0] f6, input logic [2:0] f3,
                                                input logic [4:0] vs2, input logic [4:0] vs1,
                                                input logic [4:0] vd);
        // vm bit set for unmasked
        return {f6, 1'b1, vs2, vs1, f3, vd, 7'b1010111};
    endfunction

    function automatic logic [4:0] random_reg();
        return 5'($random(seed));
    endfunction

    function automatic pe_ctrl_t pe_expect(input pe_arith_op_t op, input pe_operand_t sel,
                                           input pe_saturate_mode_t sat,
                                           input pe_output_mode_t mode);
        pe_ctrl_t p;
        p = '0;
        p.pe_op = op;
        p.operand_select = sel;
        p.saturate_mode = sat;
        p.output_mode = mode;
        return p;
    endfunction

    function automatic reg_ctrl_t reg_expect(input logic vw, input logic csr, input logic pv,
                                             input logic vmax, input vreg_wb_src_t src,
                                             input apu_result_src_t res);
        reg_ctrl_t r;
        r.vec_reg_write = vw;
        r.csr_write = csr;
        r.preserve_vl = pv;
        r.set_vl_max = vmax;
        r.vd_data_src = src;
        r.apu_result_select = res;
        return r;
    endfunction

    // one instruction from request to rvalid with checks on every exec cycle
    task automatic issue_and_check(input logic [31:0] instr, input reg_ctrl_t er,
                                   input pe_ctrl_t ep, input logic multi, input logic fix,
                                   input logic red, input logic hold);
        logic [31:0] s1;
        logic [31:0] s2;
        logic [31:0] jam1;
        logic [31:0] jam2;
        logic [4:0] step;
        logic [4:0] exp_vs1;
        logic [4:0] exp_vs2;
        logic [4:0] exp_vd;
        logic [1:0] exp_etw;
        logic [10:0] exp_imm;
        reg_ctrl_t idle_r;
        pe_ctrl_t idle_p;
        int max_count;
        int k;
        s1 = $random(seed);
        s2 = $random(seed);
        jam1 = 32'h0;
        jam2 = 32'h0;
        exp_imm = (instr[14:12] == 3'b111) ? instr[30:20] : {6'b0, instr[19:15]};
        idle_r = reg_expect(1'b0, 1'b0, 1'b0, 1'b0, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        idle_p = pe_expect(PE_ARITH_ADD, PE_OPERAND_VS1, PE_SAT_NONE, PE_OP_MODE_RESULT);
        @(negedge clk);
        assert (apu_gnt === 1'b1)
        else
        begin
            $display("grant was low when a new instruction was due");
            stop_with_failure();
        end
        // controls idle while waiting even with the last instruction still held
        check_value("reg_ctrl_o", 32'(reg_ctrl), 32'(idle_r));
        check_value("pe_ctrl_o", 32'(pe_ctrl), 32'(idle_p));
        check_value("elements_to_write_o", 32'(elements_to_write), 32'd0);
        @(posedge clk);
        apu_req <= 1'b1;
        operands <= {instr, s1, s2};
        // longest run so the busy window spans several edges
        if (hold)
            vl <= 5'd16;
        else
            vl <= 5'(($unsigned($random(seed)) % 16) + 1);
        vsew <= 2'($random(seed));
        // accept edge
        @(posedge clk);
        if (!hold)
            apu_req <= 1'b0;
        max_count = multi ? (int'(vl) - 1) / 4 : 0;
        for (k = 0; k <= max_count; k++)
        begin
            @(negedge clk);
            step = (vsew == 2'd1) ? 5'(2 * k) : 5'(k);
            exp_vs1 = instr[19:15] + step;
            exp_vs2 = instr[24:20] + step;
            exp_vd = fix ? instr[11:7] : instr[11:7] + step;
            exp_etw = (multi && k == max_count) ? (red ? 2'd1 : vl[1:0]) : 2'd0;
            check_value("core_halt_o", 32'(core_halt), 32'd1);
            check_value("apu_rvalid_o", 32'(apu_rvalid), 32'(k == max_count));
            check_value("vs1_addr_o", 32'(vs1_addr), 32'(exp_vs1));
            check_value("vs2_addr_o", 32'(vs2_addr), 32'(exp_vs2));
            check_value("vd_addr_o", 32'(vd_addr), 32'(exp_vd));
            check_value("elements_to_write_o", 32'(elements_to_write), 32'(exp_etw));
            check_value("reg_ctrl_o", 32'(reg_ctrl), 32'(er));
            check_value("pe_ctrl_o", 32'(pe_ctrl), 32'(ep));
            check_value("immediate_operand_o", 32'(immediate), 32'(exp_imm));
            check_value("scalar_operand1_o", scalar1, s1);
            check_value("scalar_operand2_o", scalar2, s2);
            if (hold)
            begin
                // new operands while busy must not be taken
                @(posedge clk);
                jam1 = $random(seed);
                jam2 = $random(seed);
                operands <= {noop_instr, jam1, jam2};
            end
        end
        if (hold)
        begin
            @(negedge clk);
            check_value("apu_gnt_o", 32'(apu_gnt), 32'd1);
            check_value("scalar_operand1_o", scalar1, s1);
            check_value("scalar_operand2_o", scalar2, s2);
            @(posedge clk);
            apu_req <= 1'b0;
            // the no-op accepted after rvalid runs one cycle
            @(negedge clk);
            check_value("core_halt_o", 32'(core_halt), 32'd1);
            check_value("apu_rvalid_o", 32'(apu_rvalid), 32'd1);
            check_value("scalar_operand1_o", scalar1, jam1);
            check_value("scalar_operand2_o", scalar2, jam2);
            check_value("reg_ctrl_o", 32'(reg_ctrl), 32'd0);
            check_value("elements_to_write_o", 32'(elements_to_write), 32'd0);
        end
    endtask

    task automatic check_table_entry(input logic [5:0] f6, input logic [2:0] f3,
                                     input pe_arith_op_t op, input pe_operand_t sel,
                                     input pe_saturate_mode_t sat, input pe_output_mode_t mode,
                                     input logic uimm, input logic [1:0] wid, input logic vw,
                                     input vreg_wb_src_t src, input apu_result_src_t res);
        pe_ctrl_t ep;
        ep = pe_expect(op, sel, sat, mode);
        ep.unsigned_immediate = uimm;
        ep.widening = wid;
        issue_and_check(encode_op_v(f6, f3, random_reg(), random_reg(), random_reg()),
                        reg_expect(vw, 1'b0, 1'b0, 1'b0, src, res), ep, vw, 1'b0, 1'b0, 1'b0);
    endtask

    initial
    begin
        int i;
        logic [5:0] f6;
        logic [2:0] f3;
        logic [4:0] cfg_rs1;
        logic [4:0] cfg_rd;
        logic [10:0] zimm;
        reg_ctrl_t er;
        pe_ctrl_t ep;
        seed = 17394;
        noop_instr = encode_op_v(6'b111111, V_OPIVV, 5'd1, 5'd2, 5'd3);
        n_reset <= 1'b0;
        apu_req <= 1'b0;
        operands <= '0;
        vl <= 5'd1;
        vsew <= 2'd0;
        repeat (10) @(posedge clk);
        n_reset <= 1'b1;
        @(negedge clk);
        check_value("apu_gnt_o", 32'(apu_gnt), 32'd1);
        check_value("apu_rvalid_o", 32'(apu_rvalid), 32'd0);
        check_value("core_halt_o", 32'(core_halt), 32'd0);
        check_value("vec_reg_write", 32'(reg_ctrl.vec_reg_write), 32'd0);
        check_value("csr_write", 32'(reg_ctrl.csr_write), 32'd0);

        // vadd.vv and vsub.vv
        er = reg_expect(1'b1, 1'b0, 1'b0, 1'b0, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        for (i = 0; i < 20; i++)
        begin
            ep = pe_expect(i[0] ? PE_ARITH_SUB : PE_ARITH_ADD, PE_OPERAND_VS1, PE_SAT_NONE,
                           PE_OP_MODE_RESULT);
            f6 = i[0] ? 6'b000010 : 6'b000000;
            issue_and_check(encode_op_v(f6, V_OPIVV, random_reg(), random_reg(), random_reg()),
                            er, ep, 1'b1, 1'b0, 1'b0, 1'b0);
        end

        // vredsum, vredmax, vwredsum
        for (i = 0; i < 12; i++)
        begin
            case (i % 3)
                0:
                begin
                    ep = pe_expect(PE_ARITH_ADD, PE_OPERAND_RIPPLE, PE_SAT_NONE,
                                   PE_OP_MODE_RESULT);
                    f6 = 6'b000000;
                    f3 = V_OPMVV;
                end
                1:
                begin
                    ep = pe_expect(PE_ARITH_SUB, PE_OPERAND_RIPPLE, PE_SAT_NONE,
                                   PE_OP_MODE_PASS_MAX);
                    f6 = 6'b000111;
                    f3 = V_OPMVV;
                end
                default:
                begin
                    ep = pe_expect(PE_ARITH_ADD, PE_OPERAND_RIPPLE, PE_SAT_NONE,
                                   PE_OP_MODE_RESULT);
                    ep.widening = 2'b01;
                    ep.wide_vs1 = 1'b1;
                    f6 = 6'b110001;
                    f3 = V_OPIVV;
                end
            endcase
            issue_and_check(encode_op_v(f6, f3, random_reg(), random_reg(), random_reg()),
                            er, ep, 1'b1, 1'b1, 1'b1, 1'b0);
        end

        // vsetvli over every rs1/rd zero combination
        ep = pe_expect(PE_ARITH_ADD, PE_OPERAND_VS1, PE_SAT_NONE, PE_OP_MODE_RESULT);
        for (i = 0; i < 8; i++)
        begin
            cfg_rs1 = i[0] ? random_reg() : 5'd0;
            cfg_rd = i[1] ? (random_reg() | 5'd1) : 5'd0;
            zimm = 11'($random(seed));
            er = reg_expect(1'b0, 1'b1, cfg_rs1 == 5'd0 && cfg_rd == 5'd0,
                            cfg_rs1 == 5'd0 && cfg_rd != 5'd0, VREG_WB_SRC_ARITH,
                            APU_RESULT_SRC_VL);
            issue_and_check({1'b0, zimm, cfg_rs1, 3'b111, cfg_rd, 7'b1010111}, er, ep,
                            1'b0, 1'b0, 1'b0, 1'b0);
        end

        check_table_entry(6'b000000, V_OPIVX, PE_ARITH_ADD, PE_OPERAND_SCALAR, PE_SAT_NONE,
            PE_OP_MODE_RESULT, 1'b0, 2'b00, 1'b1, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        check_table_entry(6'b000101, V_OPIVV, PE_ARITH_SUB, PE_OPERAND_VS1, PE_SAT_NONE,
            PE_OP_MODE_PASS_MIN, 1'b0, 2'b00, 1'b1, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        check_table_entry(6'b000111, V_OPIVX, PE_ARITH_SUB, PE_OPERAND_SCALAR, PE_SAT_NONE,
            PE_OP_MODE_PASS_MAX, 1'b0, 2'b00, 1'b1, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        check_table_entry(6'b001001, V_OPIVV, PE_ARITH_AND, PE_OPERAND_VS1, PE_SAT_NONE,
            PE_OP_MODE_RESULT, 1'b0, 2'b00, 1'b1, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        check_table_entry(6'b001010, V_OPIVV, PE_ARITH_OR, PE_OPERAND_VS1, PE_SAT_NONE,
            PE_OP_MODE_RESULT, 1'b0, 2'b00, 1'b1, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        check_table_entry(6'b001011, V_OPIVV, PE_ARITH_XOR, PE_OPERAND_VS1, PE_SAT_NONE,
            PE_OP_MODE_RESULT, 1'b0, 2'b00, 1'b1, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        check_table_entry(6'b100001, V_OPIVV, PE_ARITH_ADD, PE_OPERAND_VS1, PE_SAT,
            PE_OP_MODE_RESULT, 1'b0, 2'b00, 1'b1, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        check_table_entry(6'b100101, V_OPIVI, PE_ARITH_LSHIFT, PE_OPERAND_IMMEDIATE, PE_SAT_NONE,
            PE_OP_MODE_RESULT, 1'b0, 2'b00, 1'b1, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        check_table_entry(6'b100101, V_OPMVV, PE_ARITH_MUL, PE_OPERAND_VS1, PE_SAT_NONE,
            PE_OP_MODE_RESULT, 1'b0, 2'b00, 1'b1, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        check_table_entry(6'b100111, V_OPIVX, PE_ARITH_MUL, PE_OPERAND_SCALAR, PE_SAT_UPPER,
            PE_OP_MODE_RESULT, 1'b0, 2'b00, 1'b1, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        check_table_entry(6'b101000, V_OPIVI, PE_ARITH_RSHIFT_LOG, PE_OPERAND_IMMEDIATE,
            PE_SAT_NONE, PE_OP_MODE_RESULT, 1'b1, 2'b00, 1'b1, VREG_WB_SRC_ARITH,
            APU_RESULT_SRC_VL);
        check_table_entry(6'b101001, V_OPIVX, PE_ARITH_RSHIFT_AR, PE_OPERAND_SCALAR, PE_SAT_NONE,
            PE_OP_MODE_RESULT, 1'b0, 2'b00, 1'b1, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        check_table_entry(6'b111011, V_OPMVX, PE_ARITH_MUL, PE_OPERAND_SCALAR, PE_SAT_NONE,
            PE_OP_MODE_RESULT, 1'b0, 2'b01, 1'b1, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        check_table_entry(6'b010111, V_OPIVX, PE_ARITH_ADD, PE_OPERAND_SCALAR, PE_SAT_NONE,
            PE_OP_MODE_RESULT, 1'b0, 2'b00, 1'b1, VREG_WB_SRC_SCALAR, APU_RESULT_SRC_VL);
        // vmv.x.s only returns vs2[0] to the core
        check_table_entry(6'b010000, V_OPMVV, PE_ARITH_ADD, PE_OPERAND_VS1, PE_SAT_NONE,
            PE_OP_MODE_RESULT, 1'b0, 2'b00, 1'b0, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VS2_0);
        // unsupported funct6
        check_table_entry(6'b111111, V_OPIVV, PE_ARITH_ADD, PE_OPERAND_VS1, PE_SAT_NONE,
            PE_OP_MODE_RESULT, 1'b0, 2'b00, 1'b0, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);

        // request held high through execution
        er = reg_expect(1'b1, 1'b0, 1'b0, 1'b0, VREG_WB_SRC_ARITH, APU_RESULT_SRC_VL);
        ep = pe_expect(PE_ARITH_ADD, PE_OPERAND_VS1, PE_SAT_NONE, PE_OP_MODE_RESULT);
        issue_and_check(encode_op_v(6'b000000, V_OPIVV, random_reg(), random_reg(), random_reg()),
                        er, ep, 1'b1, 1'b0, 1'b0, 1'b1);

        @(negedge clk);
        $display("PASS: all tests");
        $finish;
    end

    initial
    begin
        repeat (n_instr * 6 + 40) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", n_instr * 6 + 40);
        stop_with_failure();
    end

endmodule

`default_nettype wire

//--- vdec_pkg.sv
// shared decoder types; only the OP-V major opcode is decoded and vl is assumed to be 1 to 16
`default_nettype none

package vdec_pkg;

    localparam int xlen = 32;
    localparam int vreg_addr_w = 5;
    localparam int vl_w = 5;
    localparam int elems_per_cycle_w = 2;
    localparam int imm_w = 11;

    typedef enum logic [6:0] {
        V_MAJOR_OP_V = 7'b1010111
    } v_major_t;

    typedef enum logic [2:0] {
        V_OPIVV = 3'b000,
        V_OPMVV = 3'b010,
        V_OPIVI = 3'b011,
        V_OPIVX = 3'b100,
        V_OPMVX = 3'b110,
        V_OPCFG = 3'b111
    } v_funct3_t;

    // vredsum shares vadd, vredmax shares vmax, vmul shares vsll
    typedef enum logic [5:0] {
        F6_VADD      = 6'b000000,
        F6_VSUB      = 6'b000010,
        F6_VMIN      = 6'b000101,
        F6_VMAX      = 6'b000111,
        F6_VAND      = 6'b001001,
        F6_VOR       = 6'b001010,
        F6_VXOR      = 6'b001011,
        F6_VWXUNARY0 = 6'b010000,
        F6_VMV       = 6'b010111,
        F6_VSADD     = 6'b100001,
        F6_VSLL      = 6'b100101,
        F6_VSMUL     = 6'b100111,
        F6_VSRL      = 6'b101000,
        F6_VSRA      = 6'b101001,
        F6_VWREDSUM  = 6'b110001,
        F6_VWMUL     = 6'b111011
    } v_funct6_t;

    // the first literal of each control enum is its idle value
    typedef enum logic [3:0] {
        PE_ARITH_ADD,
        PE_ARITH_SUB,
        PE_ARITH_AND,
        PE_ARITH_OR,
        PE_ARITH_XOR,
        PE_ARITH_LSHIFT,
        PE_ARITH_RSHIFT_LOG,
        PE_ARITH_RSHIFT_AR,
        PE_ARITH_MUL
    } pe_arith_op_t;

    typedef enum logic [1:0] {PE_SAT_NONE, PE_SAT, PE_SAT_UPPER} pe_saturate_mode_t;

    typedef enum logic [1:0] {
        PE_OP_MODE_RESULT,
        PE_OP_MODE_PASS_MIN,
        PE_OP_MODE_PASS_MAX
    } pe_output_mode_t;

    typedef enum logic [1:0] {
        PE_OPERAND_VS1,
        PE_OPERAND_SCALAR,
        PE_OPERAND_IMMEDIATE,
        PE_OPERAND_RIPPLE
    } pe_operand_t;

    typedef enum logic {VREG_WB_SRC_ARITH, VREG_WB_SRC_SCALAR} vreg_wb_src_t;

    typedef enum logic {APU_RESULT_SRC_VL, APU_RESULT_SRC_VS2_0} apu_result_src_t;

    typedef struct packed {
        logic [xlen-1:0] instr;
        logic [xlen-1:0] scalar1;
        logic [xlen-1:0] scalar2;
    } apu_operands_t;

    typedef struct packed {
        v_major_t major;
        v_funct3_t funct3;
        v_funct6_t funct6;
        logic [vreg_addr_w-1:0] source1;
        logic [vreg_addr_w-1:0] source2;
        logic [vreg_addr_w-1:0] destination;
        logic [imm_w-1:0] imm_raw;
    } instr_fields_t;

    typedef struct packed {
        logic vec_reg_write;
        logic csr_write;
        logic preserve_vl;
        logic set_vl_max;
        vreg_wb_src_t vd_data_src;
        apu_result_src_t apu_result_select;
    } reg_ctrl_t;

    typedef struct packed {
        pe_arith_op_t pe_op;
        pe_saturate_mode_t saturate_mode;
        pe_output_mode_t output_mode;
        pe_operand_t operand_select;
        logic [1:0] pe_mul_us;
        logic [1:0] widening;
        logic unsigned_immediate;
        logic wide_vs1;
    } pe_ctrl_t;

    typedef struct packed {
        logic multi_cycle;
        logic fix_vd;
        logic reduction;
    } seq_ctrl_t;

endpackage

`default_nettype wire

//--- vector_decoder.f
vdec_pkg.sv
apu_capture.sv
op_decoder.sv
element_sequencer.sv
vector_decoder.sv
tb_vector_decoder.sv

//--- vector_decoder.sv
// vector issue decoder top; one instruction in flight, grant is withheld while executing
`timescale 1ns/1ps
`default_nettype none

module vector_decoder (
    input wire clk,
    input wire n_reset,
    input wire apu_req_i,
    input wire vdec_pkg::apu_operands_t apu_operands_i,
    input wire [vdec_pkg::vl_w-1:0] vl_i,
    input wire [1:0] vsew_i,
    output logic apu_gnt_o,
    output logic apu_rvalid_o,
    output logic core_halt_o,
    output logic [vdec_pkg::xlen-1:0] scalar_operand1_o,
    output logic [vdec_pkg::xlen-1:0] scalar_operand2_o,
    output logic [vdec_pkg::imm_w-1:0] immediate_operand_o,
    output logic [vdec_pkg::vreg_addr_w-1:0] vs1_addr_o,
    output logic [vdec_pkg::vreg_addr_w-1:0] vs2_addr_o,
    output logic [vdec_pkg::vreg_addr_w-1:0] vd_addr_o,
    output logic [1:0] elements_to_write_o,
    output vdec_pkg::reg_ctrl_t reg_ctrl_o,
    output vdec_pkg::pe_ctrl_t pe_ctrl_o
);
    import vdec_pkg::*;

    logic accept;
    instr_fields_t fields;
    seq_ctrl_t seq_ctrl;

    apu_capture i_capture (
        .clk(clk),
        .n_reset(n_reset),
        .accept_i(accept),
        .operands_i(apu_operands_i),
        .fields_o(fields),
        .scalar_operand1_o(scalar_operand1_o),
        .scalar_operand2_o(scalar_operand2_o)
    );

    // the halt level doubles as the decode enable
    op_decoder i_decoder (
        .exec_i(core_halt_o),
        .fields_i(fields),
        .reg_ctrl_o(reg_ctrl_o),
        .pe_ctrl_o(pe_ctrl_o),
        .seq_ctrl_o(seq_ctrl),
        .immediate_operand_o(immediate_operand_o)
    );

    element_sequencer i_sequencer (
        .clk(clk),
        .n_reset(n_reset),
        .apu_req_i(apu_req_i),
        .vl_i(vl_i),
        .vsew_i(vsew_i),
        .fields_i(fields),
        .seq_ctrl_i(seq_ctrl),
        .accept_o(accept),
        .apu_gnt_o(apu_gnt_o),
        .apu_rvalid_o(apu_rvalid_o),
        .core_halt_o(core_halt_o),
        .vs1_addr_o(vs1_addr_o),
        .vs2_addr_o(vs2_addr_o),
        .vd_addr_o(vd_addr_o),
        .elements_to_write_o(elements_to_write_o)
    );

endmodule

`default_nettype wire
